//--- common/ooo_cfg.svh
`ifndef OOO_CFG_SVH
`define OOO_CFG_SVH

// reorder buffer entries, tag 0 is reserved for "no tag".
`define OOO_ROB_DEPTH 8

// width of a reorder buffer tag.
`define OOO_TAG_BITS 3

// issue queue slots shared by the alu and the load unit.
`define OOO_IQ_DEPTH 4

// data memory size in 32-bit words.
`define OOO_DMEM_WORDS 64

`endif

//--- common/ooo_pkg.sv
`default_nettype none

`include "ooo_cfg.svh"

package ooo_pkg;

    typedef logic [`OOO_TAG_BITS-1:0] rob_tag_t;

    typedef enum logic [4:0] {
        ADD = 5'd0, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU,
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        LUI, AUIPC, JAL, JALR,
        LW,
        NOP = 5'b11111
    } uop_op_e;

    typedef struct packed {
        logic [31:0] value;
        rob_tag_t    tag;   // nonzero while the value is pending.
    } operand_t;

    typedef struct packed {
        uop_op_e     op;
        logic [4:0]  rd;
        logic [31:0] pc;
        logic [31:0] imm;
        operand_t    src1;
        operand_t    src2;
        rob_tag_t    tag;
    } dispatch_uop_t;

    typedef union packed {
        logic [31:0] data;
        struct packed {
            logic        taken;
            logic [30:0] target;   // halfword address.
        } br;
    } cdb_payload_u;

    typedef struct packed {
        logic         valid;
        rob_tag_t     tag;
        cdb_payload_u payload;
    } cdb_t;

    typedef struct packed {
        logic        we;
        logic [4:0]  rd;
        logic [31:0] value;
        logic        redirect;
        logic [31:0] redirect_pc;
        rob_tag_t    tag;
    } commit_t;

    function automatic logic is_branch(uop_op_e op);
        return op inside {BEQ, BNE, BLT, BGE, BLTU, BGEU};
    endfunction

    // these never need an execution unit.
    function automatic logic done_at_dispatch(uop_op_e op);
        return op inside {LUI, AUIPC, JAL, NOP};
    endfunction

endpackage

`default_nettype wire

//--- rob/reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "ooo_cfg.svh"

module reorder_buffer import ooo_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  logic          disp_valid,
    input  dispatch_uop_t disp_uop,
    output rob_tag_t      alloc_tag,
    output logic          rob_full,
    input  cdb_t          cdb,
    output logic          commit_valid,
    output commit_t       commit
);

    localparam int       DEPTH = `OOO_ROB_DEPTH;
    localparam rob_tag_t LAST  = rob_tag_t'(DEPTH - 1);

    uop_op_e          rob_op    [DEPTH];
    logic [4:0]       rob_rd    [DEPTH];
    logic [31:0]      rob_pc    [DEPTH];
    logic [31:0]      rob_value [DEPTH];
    logic             rob_taken [DEPTH];
    logic [DEPTH-1:0] rob_done;
    rob_tag_t         head;
    rob_tag_t         tail;
    rob_tag_t         count;
    logic             retire;
    commit_t          commit_d;

    // wraps from the last entry back to 1.
    function automatic rob_tag_t next_tag(rob_tag_t t);
        return (t == LAST) ? rob_tag_t'(1) : rob_tag_t'(t + 1'b1);
    endfunction

    assign alloc_tag = tail;
    assign rob_full  = (count == LAST);
    assign retire    = (count != '0) && rob_done[head];

    always_comb begin
        commit_d       = '0;
        commit_d.tag   = head;
        commit_d.rd    = rob_rd[head];
        commit_d.value = rob_value[head];
        case (rob_op[head])
            BEQ, BNE, BLT, BGE, BLTU, BGEU: begin
                commit_d.redirect = rob_taken[head];
                if (rob_taken[head]) begin
                    commit_d.redirect_pc = rob_value[head];
                end
            end
            JAL: begin
                commit_d.we          = (rob_rd[head] != '0);
                commit_d.value       = rob_pc[head] + 32'd4;
                commit_d.redirect    = 1'b1;
                commit_d.redirect_pc = rob_pc[head] + rob_value[head];   // value holds imm.
            end
            JALR: begin
                commit_d.we          = (rob_rd[head] != '0);
                commit_d.value       = rob_pc[head] + 32'd4;
                commit_d.redirect    = 1'b1;
                commit_d.redirect_pc = rob_value[head];   // target from the alu.
            end
            AUIPC: begin
                commit_d.we    = (rob_rd[head] != '0);
                commit_d.value = rob_pc[head] + rob_value[head];
            end
            NOP: begin
                commit_d.we = 1'b0;
            end
            default: begin
                commit_d.we = (rob_rd[head] != '0);
            end
        endcase
        if (!commit_d.we) begin
            commit_d.rd    = '0;
            commit_d.value = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            head         <= rob_tag_t'(1);
            tail         <= rob_tag_t'(1);
            count        <= '0;
            rob_done     <= '0;
            commit_valid <= 1'b0;
        end else begin
            commit_valid <= retire;
            if (disp_valid) begin
                rob_done[tail] <= done_at_dispatch(disp_uop.op);
                tail           <= next_tag(tail);
            end
            if (cdb.valid) begin
                rob_done[cdb.tag] <= 1'b1;
            end
            if (retire) begin
                head <= next_tag(head);
            end
            case ({disp_valid, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (disp_valid) begin
            rob_op[tail]    <= disp_uop.op;
            rob_rd[tail]    <= disp_uop.rd;
            rob_pc[tail]    <= disp_uop.pc;
            rob_value[tail] <= disp_uop.imm;
            rob_taken[tail] <= 1'b0;
        end
        if (cdb.valid) begin
            if (is_branch(rob_op[cdb.tag])) begin
                rob_taken[cdb.tag] <= cdb.payload.br.taken;
                rob_value[cdb.tag] <= {cdb.payload.br.target, 1'b0};
            end else begin
                rob_value[cdb.tag] <= cdb.payload.data;
            end
        end
        if (retire) begin
            commit <= commit_d;
        end
    end

endmodule

`default_nettype wire

//--- source/issue_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "ooo_cfg.svh"

module issue_queue import ooo_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  logic          disp_valid,
    input  dispatch_uop_t disp_uop,
    output logic          iq_full,
    input  cdb_t          cdb,
    input  logic          alu_busy,
    output logic          alu_issue,
    output logic          load_issue,
    output dispatch_uop_t issue_uop
);

    localparam int DEPTH = `OOO_IQ_DEPTH;
    localparam int IW    = $clog2(DEPTH);

    dispatch_uop_t    ent   [DEPTH];
    logic [DEPTH-1:0] ent_valid;
    logic [DEPTH-1:0] older [DEPTH];   // older[i][j] set when slot j is older than slot i.
    logic [DEPTH-1:0] is_load;
    logic [DEPTH-1:0] ready;
    logic [DEPTH-1:0] cand;
    logic [DEPTH-1:0] sel;
    logic [IW-1:0]    sel_idx;
    logic [IW-1:0]    free_idx;
    logic             insert;
    dispatch_uop_t    disp_woken;

    function automatic operand_t wake(operand_t src, cdb_t bus);
        operand_t res;
        res = src;
        if (bus.valid && src.tag == bus.tag) begin
            res.value = bus.payload.data;
            res.tag   = '0;
        end
        return res;
    endfunction

    assign insert  = disp_valid && !done_at_dispatch(disp_uop.op);
    assign iq_full = &ent_valid;

    always_comb begin
        disp_woken      = disp_uop;
        disp_woken.src1 = wake(disp_uop.src1, cdb);   // result may land on the dispatch cycle.
        disp_woken.src2 = wake(disp_uop.src2, cdb);
    end

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            is_load[i] = (ent[i].op == LW);
            ready[i]   = ent_valid[i] && (ent[i].src1.tag == '0) && (ent[i].src2.tag == '0);
        end
        cand = ready & (is_load | {DEPTH{!alu_busy}});
        // oldest candidate wins.
        sel     = '0;
        sel_idx = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (cand[i] && !(|(older[i] & cand))) begin
                sel[i]  = 1'b1;
                sel_idx = IW'(i);
            end
        end
        free_idx = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (!ent_valid[i]) begin
                free_idx = IW'(i);
            end
        end
    end

    assign alu_issue  = |(sel & ~is_load);
    assign load_issue = |(sel & is_load);
    assign issue_uop  = ent[sel_idx];

    always_ff @(posedge clk) begin
        if (!rst) begin
            ent_valid <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                older[i] <= '0;
            end
        end else begin
            if (alu_issue || load_issue) begin
                ent_valid[sel_idx] <= 1'b0;
            end
            if (insert) begin
                ent_valid[free_idx] <= 1'b1;
                for (int i = 0; i < DEPTH; i++) begin
                    older[i][free_idx] <= 1'b0;
                end
                older[free_idx] <= ent_valid & ~sel;   // every survivor is older.
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            ent[i].src1 <= wake(ent[i].src1, cdb);
            ent[i].src2 <= wake(ent[i].src2, cdb);
        end
        if (insert) begin
            ent[free_idx] <= disp_woken;
        end
    end

endmodule

`default_nettype wire

//--- source/int_alu.sv
`timescale 1ns/1ps
`default_nettype none

module int_alu import ooo_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  logic          issue,
    input  dispatch_uop_t uop,
    input  logic          grant,
    output logic          req,
    output cdb_t          result,
    output logic          busy
);

    logic [31:0]  a;
    logic [31:0]  b;
    logic [31:0]  target;
    logic         taken;
    cdb_payload_u pay;
    rob_tag_t     res_tag;
    cdb_payload_u res_pay;

    assign a      = uop.src1.value;
    assign b      = uop.src2.value;   // immediate already folded in.
    assign target = uop.pc + uop.imm;

    always_comb begin
        case (uop.op)
            BEQ:     taken = (a == b);
            BNE:     taken = (a != b);
            BLT:     taken = ($signed(a) < $signed(b));
            BGE:     taken = ($signed(a) >= $signed(b));
            BLTU:    taken = (a < b);
            BGEU:    taken = (a >= b);
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        pay.data = '0;
        case (uop.op)
            ADD:  pay.data = a + b;
            SUB:  pay.data = a - b;
            AND:  pay.data = a & b;
            OR:   pay.data = a | b;
            XOR:  pay.data = a ^ b;
            SLL:  pay.data = a << b[4:0];
            SRL:  pay.data = a >> b[4:0];
            SRA:  pay.data = $signed(a) >>> b[4:0];
            SLT:  pay.data = {31'd0, $signed(a) < $signed(b)};
            SLTU: pay.data = {31'd0, a < b};
            JALR: pay.data = (a + uop.imm) & ~32'd1;   // jump target, link value is formed at commit.
            BEQ, BNE, BLT, BGE, BLTU, BGEU: begin
                pay.br.taken  = taken;
                pay.br.target = target[31:1];
            end
            default: pay.data = '0;
        endcase
    end

    // result stays put until the bus takes it.
    always_ff @(posedge clk) begin
        if (!rst) begin
            req <= 1'b0;
        end else if (issue) begin
            req <= 1'b1;
        end else if (grant) begin
            req <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            res_tag <= uop.tag;
            res_pay <= pay;
        end
    end

    assign busy = req & ~grant;

    always_comb begin
        result.valid   = req;
        result.tag     = res_tag;
        result.payload = res_pay;
    end

endmodule

`default_nettype wire

//--- source/load_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "ooo_cfg.svh"

module load_unit import ooo_pkg::*; (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                issue,
    input  dispatch_uop_t                       uop,
    input  logic                                grant,
    output logic                                req,
    output cdb_t                                result,
    input  logic                                mem_we,
    input  logic [$clog2(`OOO_DMEM_WORDS)-1:0] mem_addr,
    input  logic [31:0]                         mem_wdata
);

    localparam int AW = $clog2(`OOO_DMEM_WORDS);

    logic [31:0]   mem [`OOO_DMEM_WORDS];
    logic [31:0]   addr;
    logic          s1_valid;
    rob_tag_t      s1_tag;
    logic [AW-1:0] s1_index;
    rob_tag_t      res_tag;
    logic [31:0]   res_data;

    assign addr = uop.src1.value + uop.imm;

    always_ff @(posedge clk) begin
        if (!rst) begin
            s1_valid <= 1'b0;
            req      <= 1'b0;
        end else begin
            s1_valid <= issue;
            if (s1_valid) begin
                req <= 1'b1;
            end else if (grant) begin
                req <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            s1_tag   <= uop.tag;
            s1_index <= addr[AW+1:2];   // word index.
        end
        if (s1_valid) begin
            res_tag  <= s1_tag;
            res_data <= mem[s1_index];
        end
        if (mem_we) begin
            mem[mem_addr] <= mem_wdata;
        end
    end

    always_comb begin
        result.valid        = req;
        result.tag          = res_tag;
        result.payload.data = res_data;
    end

endmodule

`default_nettype wire

//--- source/cdb_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module cdb_arbiter import ooo_pkg::*; (
    input  logic load_req,
    input  cdb_t load_result,
    input  logic alu_req,
    input  cdb_t alu_result,
    output logic load_grant,
    output logic alu_grant,
    output cdb_t cdb
);

    // load has priority, it cannot hold a result.
    assign load_grant = load_req;
    assign alu_grant  = alu_req & ~load_req;

    always_comb begin
        if (load_req) begin
            cdb = load_result;
        end else if (alu_req) begin
            cdb = alu_result;
        end else begin
            cdb = '0;
        end
        cdb.valid = load_req | alu_req;
    end

endmodule

`default_nettype wire

//--- source/ooo_core_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "ooo_cfg.svh"

module ooo_core_top import ooo_pkg::*; (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                disp_valid,
    input  dispatch_uop_t                       disp_uop,
    input  logic                                mem_we,
    input  logic [$clog2(`OOO_DMEM_WORDS)-1:0] mem_addr,
    input  logic [31:0]                         mem_wdata,
    output logic                                stall,
    output logic                                commit_valid,
    output commit_t                             commit
);

    rob_tag_t      alloc_tag;
    logic          rob_full;
    logic          iq_full;
    logic          disp_fire;
    dispatch_uop_t disp_tagged;
    logic          alu_busy;
    logic          alu_issue;
    logic          load_issue;
    dispatch_uop_t issue_uop;
    logic          alu_req;
    logic          alu_grant;
    cdb_t          alu_result;
    logic          load_req;
    logic          load_grant;
    cdb_t          load_result;
    cdb_t          cdb;

    assign stall     = rob_full | iq_full;
    assign disp_fire = disp_valid & ~stall;

    always_comb begin
        disp_tagged     = disp_uop;
        disp_tagged.tag = alloc_tag;
    end

    reorder_buffer reorder_buffer_inst (
        .clk          (clk),
        .rst          (rst),
        .disp_valid   (disp_fire),
        .disp_uop     (disp_tagged),
        .alloc_tag    (alloc_tag),
        .rob_full     (rob_full),
        .cdb          (cdb),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

    issue_queue issue_queue_inst (
        .clk        (clk),
        .rst        (rst),
        .disp_valid (disp_fire),
        .disp_uop   (disp_tagged),
        .iq_full    (iq_full),
        .cdb        (cdb),
        .alu_busy   (alu_busy),
        .alu_issue  (alu_issue),
        .load_issue (load_issue),
        .issue_uop  (issue_uop)
    );

    int_alu int_alu_inst (
        .clk    (clk),
        .rst    (rst),
        .issue  (alu_issue),
        .uop    (issue_uop),
        .grant  (alu_grant),
        .req    (alu_req),
        .result (alu_result),
        .busy   (alu_busy)
    );

    load_unit load_unit_inst (
        .clk       (clk),
        .rst       (rst),
        .issue     (load_issue),
        .uop       (issue_uop),
        .grant     (load_grant),
        .req       (load_req),
        .result    (load_result),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata)
    );

    cdb_arbiter cdb_arbiter_inst (
        .load_req    (load_req),
        .load_result (load_result),
        .alu_req     (alu_req),
        .alu_result  (alu_result),
        .load_grant  (load_grant),
        .alu_grant   (alu_grant),
        .cdb         (cdb)
    );

endmodule

`default_nettype wire

//--- bench/ooo_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "ooo_cfg.svh"

module ooo_core_tb import ooo_pkg::*; ();

    localparam int MAX_ROWS = 64;
    localparam int WORDS    = `OOO_DMEM_WORDS;
    localparam int AW       = $clog2(WORDS);

    logic          clk;
    logic          rst;
    logic          disp_valid;
    dispatch_uop_t disp_uop;
    logic          mem_we;
    logic [AW-1:0] mem_addr;
    logic [31:0]   mem_wdata;
    logic          stall;
    logic          commit_valid;
    commit_t       commit;

    // a source of 0 takes the literal value, k takes the result of the row k places back.
    uop_op_e     row_op   [MAX_ROWS];
    logic [4:0]  row_rd   [MAX_ROWS];
    logic [31:0] row_imm  [MAX_ROWS];
    int          row_s1   [MAX_ROWS];
    logic [31:0] row_v1   [MAX_ROWS];
    int          row_s2   [MAX_ROWS];
    logic [31:0] row_v2   [MAX_ROWS];
    int          test_end [5];
    string       test_name [5];
    int          num_rows;
    int          num_tests;

    logic [31:0] ref_mem    [WORDS];
    logic [31:0] ref_val    [MAX_ROWS];
    commit_t     exp_commit [MAX_ROWS];
    logic        bcast      [MAX_ROWS];   // result already seen on the cdb.
    int          tag_owner  [`OOO_ROB_DEPTH];

    int   cycles;
    int   limit;
    int   errors;
    int   checks;
    int   commits;
    int   accepted;
    int   acc_unit;
    int   done_unit;
    int   first;
    int   err_start;
    logic running;
    logic stall_seen;

    ooo_core_top ooo_core_top_inst (
        .clk          (clk),
        .rst          (rst),
        .disp_valid   (disp_valid),
        .disp_uop     (disp_uop),
        .mem_we       (mem_we),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .stall        (stall),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] fill_word(int a);
        return (a * 32'h9e3779b1) ^ 32'h00000f3c;
    endfunction

    function automatic logic [31:0] pc_of(int r);
        return 32'h00001000 + r * 4;
    endfunction

    function automatic logic skips_queue(uop_op_e op);
        return op inside {LUI, AUIPC, JAL, NOP};
    endfunction

    function automatic logic branch_taken(uop_op_e op, logic [31:0] a, logic [31:0] b);
        case (op)
            BEQ:     return a == b;
            BNE:     return a != b;
            BLT:     return $signed(a) < $signed(b);
            BGE:     return $signed(a) >= $signed(b);
            BLTU:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic add_row(input uop_op_e op, input logic [4:0] rd, input logic [31:0] imm,
                           input int s1, input logic [31:0] v1,
                           input int s2, input logic [31:0] v2);
        row_op[num_rows]  = op;
        row_rd[num_rows]  = rd;
        row_imm[num_rows] = imm;
        row_s1[num_rows]  = s1;
        row_v1[num_rows]  = v1;
        row_s2[num_rows]  = s2;
        row_v2[num_rows]  = v2;
        num_rows++;
    endtask

    task automatic close_test(input string name);
        test_name[num_tests] = name;
        test_end[num_tests]  = num_rows;
        num_tests++;
    endtask

    // in-order reference, one commit record per row.
    task automatic build_model();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] pc;
        logic [31:0] ea;
        logic [31:0] v;
        logic        wr;
        commit_t     c;
        for (int r = 0; r < num_rows; r++) begin
            a  = (row_s1[r] == 0) ? row_v1[r] : ref_val[r - row_s1[r]];
            b  = (row_s2[r] == 0) ? row_v2[r] : ref_val[r - row_s2[r]];
            pc = pc_of(r);
            ea = a + row_imm[r];
            c  = '0;
            v  = '0;
            wr = 1'b1;
            case (row_op[r])
                ADD:   v = a + b;
                SUB:   v = a - b;
                AND:   v = a & b;
                OR:    v = a | b;
                XOR:   v = a ^ b;
                SLL:   v = a << b[4:0];
                SRL:   v = a >> b[4:0];
                SRA:   v = $signed(a) >>> b[4:0];
                SLT:   v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                SLTU:  v = (a < b) ? 32'd1 : 32'd0;
                LUI:   v = row_imm[r];
                AUIPC: v = pc + row_imm[r];
                LW:    v = ref_mem[ea[AW+1:2]];
                JAL, JALR: begin
                    v             = pc + 32'd4;
                    c.redirect    = 1'b1;
                    c.redirect_pc = (row_op[r] == JAL) ? pc + row_imm[r] : ea & ~32'd1;
                end
                NOP: wr = 1'b0;
                default: begin
                    wr         = 1'b0;
                    c.redirect = branch_taken(row_op[r], a, b);
                    if (c.redirect) begin
                        c.redirect_pc = pc + row_imm[r];
                    end
                end
            endcase
            ref_val[r] = v;
            c.tag      = rob_tag_t'(r % (`OOO_ROB_DEPTH - 1) + 1);
            if (wr && row_rd[r] != 5'd0) begin
                c.we    = 1'b1;
                c.rd    = row_rd[r];
                c.value = v;
            end
            exp_commit[r] = c;
        end
    endtask

    // value if the producer is known, its tag otherwise.
    function automatic operand_t form_operand(int r, int s, logic [31:0] v);
        operand_t o;
        int       p;
        o = '0;
        if (s == 0) begin
            o.value = v;
        end else begin
            p = r - s;
            if (skips_queue(row_op[p]) || bcast[p]) begin
                o.value = ref_val[p];
            end else begin
                o.tag = exp_commit[p].tag;
            end
        end
        return o;
    endfunction

    task automatic drive_row(input int r);
        dispatch_uop_t u;
        logic          taken_in;
        taken_in = 1'b0;
        while (!taken_in) begin
            u          = '0;
            u.op       = row_op[r];
            u.rd       = row_rd[r];
            u.pc       = pc_of(r);
            u.imm      = row_imm[r];
            u.src1     = form_operand(r, row_s1[r], row_v1[r]);
            u.src2     = form_operand(r, row_s2[r], row_v2[r]);
            disp_uop   = u;
            disp_valid = 1'b1;
            taken_in   = !stall;
            stall_seen = stall_seen | stall;
            @(posedge clk);
            if (taken_in) begin
                tag_owner[exp_commit[r].tag] = r;
                accepted++;
                if (!skips_queue(row_op[r])) begin
                    acc_unit++;
                end
            end
            #1;
        end
    endtask

    task automatic check_commit(input commit_t got);
        checks++;
        if (got !== exp_commit[commits]) begin
            $display("[ERROR] commit row %0d: got %h, expected %h", commits, got,
                     exp_commit[commits]);
            errors++;
        end
    endtask

    task automatic check_stall(input logic expected);
        checks++;
        if (stall !== expected) begin
            $display("[ERROR] stall: got %h, expected %h", stall, expected);
            errors++;
        end
    endtask

    always @(negedge clk) begin
        if (running) begin
            if (ooo_core_top_inst.cdb.valid) begin
                bcast[tag_owner[ooo_core_top_inst.cdb.tag]] = 1'b1;
            end
            if (commit_valid) begin
                if (commits >= num_rows) begin
                    $display("a commit arrived after the last row had retired, tag %0d",
                             commit.tag);
                    errors++;
                end else begin
                    check_commit(commit);
                    if (!skips_queue(row_op[commits])) begin
                        done_unit++;
                    end
                end
                commits++;
            end
            // the queue cannot be full with fewer unit ops in flight than slots.
            if (acc_unit - done_unit < `OOO_IQ_DEPTH) begin
                check_stall((accepted - commits) == (`OOO_ROB_DEPTH - 1));
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= limit) begin
            $display("timeout: the run did not finish within %0d cycles", limit);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        clk        = 1'b0;
        rst        = 1'b0;
        disp_valid = 1'b0;
        disp_uop   = '0;
        mem_we     = 1'b0;
        mem_addr   = '0;
        mem_wdata  = '0;
        running    = 1'b0;
        stall_seen = 1'b0;
        cycles     = 0;
        errors     = 0;
        checks     = 0;
        commits    = 0;
        accepted   = 0;
        acc_unit   = 0;
        done_unit  = 0;
        num_rows   = 0;
        num_tests  = 0;
        for (int i = 0; i < MAX_ROWS; i++) begin
            bcast[i] = 1'b0;
        end
        for (int i = 0; i < `OOO_ROB_DEPTH; i++) begin
            tag_owner[i] = 0;
        end
        for (int i = 0; i < WORDS; i++) begin
            ref_mem[i] = fill_word(i);
        end

        add_row(ADD, 5'd1, 32'hfffffff0, 0, 32'h00001234, 0, 32'hfffffff0);
        add_row(SUB, 5'd2, 32'h0, 0, 32'h00000010, 0, 32'h00000025);
        add_row(AND, 5'd3, 32'h0, 0, 32'hf0f01234, 0, 32'h0ff000ff);
        add_row(OR, 5'd4, 32'h0, 0, 32'h12000000, 0, 32'h00000034);
        add_row(XOR, 5'd5, 32'hffffffff, 0, 32'haaaa5555, 0, 32'hffffffff);
        add_row(SLL, 5'd6, 32'h0, 0, 32'h80000001, 0, 32'h00000021);
        add_row(SRL, 5'd7, 32'h4, 0, 32'h80000000, 0, 32'h00000004);
        add_row(SRA, 5'd8, 32'h4, 0, 32'h80000000, 0, 32'h00000004);
        add_row(SLT, 5'd9, 32'h0, 0, 32'hfffffffe, 0, 32'h00000001);
        add_row(SLTU, 5'd10, 32'h0, 0, 32'hfffffffe, 0, 32'h00000001);
        add_row(SLT, 5'd0, 32'h0, 0, 32'h00000005, 0, 32'h00000003);
        close_test("independent alu ops");
        add_row(LW, 5'd11, 32'h20, 0, 32'h0, 0, 32'h0);
        add_row(ADD, 5'd12, 32'h5, 1, 32'h0, 0, 32'h00000005);
        add_row(XOR, 5'd13, 32'h0, 0, 32'h00001111, 0, 32'h00000f0f);
        add_row(SLL, 5'd14, 32'h3, 2, 32'h0, 0, 32'h00000003);
        add_row(SUB, 5'd15, 32'h0, 1, 32'h0, 4, 32'h0);
        add_row(SLTU, 5'd16, 32'h0, 2, 32'h0, 3, 32'h0);
        add_row(ADD, 5'd17, 32'h9, 0, 32'h00000007, 0, 32'h00000009);
        add_row(ADD, 5'd18, 32'h0, 1, 32'h0, 1, 32'h0);
        close_test("dependency chain");
        add_row(LW, 5'd19, 32'h4, 0, 32'h00000100, 0, 32'h0);
        add_row(ADD, 5'd20, 32'h17, 0, 32'h00000064, 0, 32'h00000017);
        add_row(OR, 5'd21, 32'h0, 2, 32'h0, 1, 32'h0);
        add_row(LW, 5'd22, 32'h3c, 0, 32'h0, 0, 32'h0);
        add_row(SRA, 5'd23, 32'h8, 0, 32'hf0000000, 0, 32'h00000008);
        add_row(SUB, 5'd24, 32'h0, 1, 32'h0, 2, 32'h0);
        close_test("load and alu collision");
        add_row(LUI, 5'd5, 32'h12345000, 0, 32'h0, 0, 32'h0);
        add_row(AUIPC, 5'd6, 32'h00002000, 0, 32'h0, 0, 32'h0);
        add_row(ADD, 5'd7, 32'h0, 2, 32'h0, 1, 32'h0);
        add_row(BEQ, 5'd0, 32'h40, 0, 32'h7, 0, 32'h7);
        add_row(BNE, 5'd0, 32'h80, 0, 32'h7, 0, 32'h7);
        add_row(BLT, 5'd0, 32'hffffffe0, 0, 32'hfffffffb, 0, 32'h3);
        add_row(BGE, 5'd0, 32'h10, 0, 32'hfffffffb, 0, 32'h3);
        add_row(BLTU, 5'd0, 32'h10, 0, 32'hfffffffb, 0, 32'h3);
        add_row(BGEU, 5'd0, 32'h100, 6, 32'h0, 0, 32'h3);
        add_row(JAL, 5'd1, 32'h800, 0, 32'h0, 0, 32'h0);
        add_row(JALR, 5'd2, 32'h123, 10, 32'h0, 0, 32'h0);
        add_row(JALR, 5'd0, 32'h0, 0, 32'h00003001, 0, 32'h0);
        add_row(NOP, 5'd0, 32'h0, 0, 32'h0, 0, 32'h0);
        close_test("branches, jumps and upper immediates");
        add_row(LW, 5'd1, 32'h10, 0, 32'h0, 0, 32'h0);
        add_row(LW, 5'd2, 32'h0, 1, 32'h0, 0, 32'h0);
        add_row(LW, 5'd3, 32'h4, 1, 32'h0, 0, 32'h0);
        add_row(LW, 5'd4, 32'h8, 1, 32'h0, 0, 32'h0);
        for (int k = 0; k < 6; k++) begin
            add_row(LUI, 5'(5 + k), (k + 1) << 12, 0, 32'h0, 0, 32'h0);
        end
        add_row(ADD, 5'd11, 32'h0, 7, 32'h0, 9, 32'h0);
        add_row(OR, 5'd12, 32'h0, 1, 32'h0, 2, 32'h0);
        close_test("rob overflow under a load chain");

        build_model();
        limit = 40 * num_rows + 200;

        repeat (10) @(posedge clk);
        #1;
        rst = 1'b1;
        for (int i = 0; i < WORDS; i++) begin
            mem_we    = 1'b1;
            mem_addr  = AW'(i);
            mem_wdata = fill_word(i);
            @(posedge clk);
            #1;
        end
        mem_we  = 1'b0;
        running = 1'b1;

        first = 0;
        for (int t = 0; t < num_tests; t++) begin
            err_start  = errors;
            stall_seen = 1'b0;
            for (int r = first; r < test_end[t]; r++) begin
                drive_row(r);
            end
            disp_valid = 1'b0;
            while (commits < test_end[t]) begin
                @(posedge clk);
            end
            #1;
            if (t == num_tests - 1 && !stall_seen) begin
                $display("stall never rose while more micro-ops were sent than the ROB holds");
                errors++;
            end
            $display("test %0d (%s) done: %0d micro-ops, %0d errors", t + 1, test_name[t],
                     test_end[t] - first, errors - err_start);
            first = test_end[t];
        end

        repeat (5) @(posedge clk);   // catch stray commits.
        $display("%0d tests, %0d commits, %0d checks, %0d errors", num_tests, commits, checks,
                 errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- ooo_core.f
+incdir+common
common/ooo_pkg.sv
rob/reorder_buffer.sv
source/issue_queue.sv
source/int_alu.sv
source/load_unit.sv
source/cdb_arbiter.sv
source/ooo_core_top.sv
bench/ooo_core_tb.sv
